//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module ram_sweep_tb \
		-f sources.f -Mdir obj_dir -o ram_sweep_sim
	./obj_dir/ram_sweep_sim | tee sim.log
	@grep -q -F -x "** PASS **" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sources.f
verilog/ram_sweep_pkg.sv
verilog/bram_tdp.sv
verilog/host_pipe_port.sv
verilog/word_increment_lane.sv
verilog/half_shift_lane.sv
verilog/sweep_sequencer.sv
verilog/ram_sweep_top.sv
verification/ram_sweep_tb.sv

//--- verification/ram_sweep_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ram_sweep_tb;
    import ram_sweep_pkg::*;

    localparam int WORDS_LOG2   = 4;
    localparam int WORDS        = 1 << WORDS_LOG2;
    localparam int HALVES       = 2 * WORDS;
    // Start to done distance is three cycles per word plus one
    localparam int SWEEP_CYCLES = 3 * WORDS + 1;
    localparam int N_CASES      = 8;
    localparam int WATCHDOG_CYCLES = N_CASES * (2 * HALVES + 3 * WORDS + 20);

    // One table row with halves[2k] as lo and halves[2k+1] as hi of word k
    typedef struct packed {
        mode_e                   mode;
        logic                    sweep;
        logic                    rand_fill;
        logic [HALVES-1:0][15:0] halves;
    } case_t;

    logic        a_clk = 1'b0;
    logic        reset;
    logic        pipe_in_write;
    half_t       pipe_in_data;
    logic        pipe_out_read;
    logic        rewind;
    logic        start;
    mode_e       mode;
    half_t       pipe_out_data;
    logic        busy;
    logic        done;
    logic [15:0] overflow_count;

    case_t       cases [N_CASES];
    logic [15:0] exp_halves [HALVES];
    int          exp_ovf;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          r;
    int          err_before;

    always #5 a_clk = ~a_clk;

    ram_sweep_top #(
        .WORDS_LOG2 (WORDS_LOG2)
    ) dut (
        .a_clk          (a_clk),
        .reset          (reset),
        .pipe_in_write  (pipe_in_write),
        .pipe_in_data   (pipe_in_data),
        .pipe_out_read  (pipe_out_read),
        .rewind         (rewind),
        .start          (start),
        .mode           (mode),
        .pipe_out_data  (pipe_out_data),
        .busy           (busy),
        .done           (done),
        .overflow_count (overflow_count)
    );

    // Drive point 1 ns past the rising edge
    task automatic next_cycle();
        @(posedge a_clk);
        #1;
    endtask

    // Edge values first and random rows filled afterwards
    task automatic fill_table();
        int i;
        int k;
        cases[0] = '{MODE_INCREMENT, 1'b0, 1'b0,
                     {8{16'h7FFF, 16'hFFFF, 16'h8000, 16'h0000}}};
        cases[1] = '{MODE_INCREMENT, 1'b1, 1'b0,
                     {8{16'h7FFF, 16'hFFFF, 16'h8000, 16'h0000}}};
        cases[2] = '{MODE_INCREMENT, 1'b1, 1'b0, {32{16'hFFFF}}};
        cases[3] = '{MODE_HALF_SHIFT, 1'b1, 1'b0,
                     {8{16'h2000, 16'h1FFF, 16'hE000, 16'hDFFF}}};
        cases[4] = '{MODE_HALF_SHIFT, 1'b1, 1'b0,
                     {8{16'h7FFF, 16'h8000, 16'hFFFF, 16'h0001}}};
        cases[5] = '{MODE_INCREMENT, 1'b1, 1'b1, '0};
        cases[6] = '{MODE_HALF_SHIFT, 1'b1, 1'b1, '0};
        cases[7] = '{MODE_HALF_SHIFT, 1'b0, 1'b1, '0};
        for (k = 0; k < N_CASES; k++) begin
            if (cases[k].rand_fill) begin
                for (i = 0; i < HALVES; i++) begin
                    cases[k].halves[i] = 16'($urandom());
                end
            end
        end
    endtask

    // Shifted value no longer fits in 16 signed bits
    function automatic logic shift_loses_sign(input logic [15:0] h);
        int v;
        v = int'($signed(h)) * 4;
        return (v > 32767) || (v < -32768);
    endfunction

    // Expected halves and overflow count from the lane rules
    task automatic compute_reference(input int row);
        int          k;
        logic [15:0] lo;
        logic [15:0] hi;
        logic [31:0] w;
        exp_ovf = 0;
        for (k = 0; k < WORDS; k++) begin
            lo = cases[row].halves[2*k];
            hi = cases[row].halves[2*k+1];
            w  = {hi, lo};
            if (!cases[row].sweep) begin
                exp_halves[2*k]   = lo;
                exp_halves[2*k+1] = hi;
            end else if (cases[row].mode == MODE_INCREMENT) begin
                // Largest positive word wraps
                if (w == 32'h7FFF_FFFF) begin
                    exp_ovf++;
                end
                w = w + 32'd1;
                exp_halves[2*k]   = w[15:0];
                exp_halves[2*k+1] = w[31:16];
            end else begin
                if (shift_loses_sign(hi) || shift_loses_sign(lo)) begin
                    exp_ovf++;
                end
                exp_halves[2*k]   = {lo[13:0], 2'b00};
                exp_halves[2*k+1] = {hi[13:0], 2'b00};
            end
        end
    endtask

    // Rewind and then stream all halves in
    task automatic load_halves(input int row);
        int i;
        rewind = 1'b1;
        next_cycle();
        rewind = 1'b0;
        for (i = 0; i < HALVES; i++) begin
            pipe_in_write = 1'b1;
            pipe_in_data  = cases[row].halves[i];
            next_cycle();
        end
        pipe_in_write = 1'b0;
    endtask

    // Start pulse plus a second start and a mode flip mid-sweep
    task automatic run_sweep(input int row);
        int   cyc;
        logic seen_done;
        start     = 1'b1;
        mode      = cases[row].mode;
        cyc       = 0;
        seen_done = 1'b0;
        while (!seen_done && cyc < SWEEP_CYCLES + 8) begin
            next_cycle();
            cyc++;
            if (done) begin
                seen_done = 1'b1;
                if (cyc != SWEEP_CYCLES) begin
                    errors++;
                    $display("case %0d: done came %0d cycles after start, expected %0d",
                             row, cyc, SWEEP_CYCLES);
                end
                if (busy !== 1'b0) begin
                    errors++;
                    $display("mismatch busy with done: got %h expected %h", busy, 1'b0);
                end
                if (overflow_count !== 16'(exp_ovf)) begin
                    errors++;
                    $display("mismatch overflow_count: got %h expected %h",
                             overflow_count, 16'(exp_ovf));
                end
            end else if (busy !== 1'b1) begin
                errors++;
                $display("mismatch busy at cycle %0d: got %h expected %h", cyc, busy, 1'b1);
            end
            // Ignored while busy
            if (cyc == 1) begin
                start = 1'b0;
            end else if (cyc == 10) begin
                start = 1'b1;
                mode  = (cases[row].mode == MODE_INCREMENT) ? MODE_HALF_SHIFT
                                                             : MODE_INCREMENT;
            end else if (cyc == 11) begin
                start = 1'b0;
                mode  = cases[row].mode;
            end
        end
        if (!seen_done) begin
            errors++;
            $display("case %0d: done never pulsed within %0d cycles of start",
                     row, SWEEP_CYCLES + 8);
        end
        next_cycle();
        // One-cycle pulse and no restart
        if (done !== 1'b0 || busy !== 1'b0) begin
            errors++;
            $display("mismatch busy/done after sweep: got %h expected %h", {busy, done}, 2'b00);
        end
    endtask

    // Rewind and then stream all halves out and compare
    task automatic read_back(input int row);
        int i;
        rewind = 1'b1;
        next_cycle();
        rewind = 1'b0;
        pipe_out_read = 1'b1;
        for (i = 0; i < HALVES; i++) begin
            next_cycle();
            if (i == HALVES - 1) begin
                pipe_out_read = 1'b0;
            end
            if (pipe_out_data !== exp_halves[i]) begin
                errors++;
                $display("mismatch pipe_out_data[%0d]: got %h expected %h",
                         i, pipe_out_data, exp_halves[i]);
            end
        end
        // Idle cycle keeps the last word on the pipe
        next_cycle();
        if (pipe_out_data !== exp_halves[HALVES-1]) begin
            errors++;
            $display("mismatch pipe_out_data held: got %h expected %h",
                     pipe_out_data, exp_halves[HALVES-1]);
        end
        // Count holds until the next start
        if (cases[row].sweep && overflow_count !== 16'(exp_ovf)) begin
            errors++;
            $display("mismatch overflow_count after read: got %h expected %h",
                     overflow_count, 16'(exp_ovf));
        end
    endtask

    function automatic string case_label(input int row);
        if (!cases[row].sweep) begin
            return "load and read back";
        end else if (cases[row].mode == MODE_HALF_SHIFT) begin
            return "half shift sweep";
        end
        return "increment sweep";
    endfunction

    task automatic finish_test(input string name, input int err_start);
        if (errors == err_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_start);
        end
    endtask

    initial begin
        reset         = 1'b1;
        pipe_in_write = 1'b0;
        pipe_in_data  = '0;
        pipe_out_read = 1'b0;
        rewind        = 1'b0;
        start         = 1'b0;
        mode          = MODE_INCREMENT;
        errors        = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        void'($urandom(51));
        fill_table();
        repeat (2) @(posedge a_clk);
        #1;
        reset = 1'b0;

        // Idle state straight out of reset
        err_before = errors;
        if (busy !== 1'b0 || done !== 1'b0) begin
            errors++;
            $display("mismatch busy/done after reset: got %h expected %h", {busy, done}, 2'b00);
        end
        if (overflow_count !== 16'h0000) begin
            errors++;
            $display("mismatch overflow_count after reset: got %h expected %h",
                     overflow_count, 16'h0000);
        end
        finish_test("reset state", err_before);

        for (r = 0; r < N_CASES; r++) begin
            err_before = errors;
            compute_reference(r);
            load_halves(r);
            if (cases[r].sweep) begin
                run_sweep(r);
            end
            read_back(r);
            finish_test($sformatf("%0d %s", r, case_label(r)), err_before);
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Budget sized from the case count and the sweep length
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge a_clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/bram_tdp.sv
`timescale 1ns/1ps
`default_nettype none

module bram_tdp #(
    parameter int WORDS_LOG2 = 9
) (
    input  wire                        a_clk,
    // Port A, host side, 16-bit halves
    input  wire                        a_wr,
    input  wire  [WORDS_LOG2:0]        a_addr,
    input  wire  ram_sweep_pkg::half_t a_din,
    output ram_sweep_pkg::half_t       a_dout,
    // Port B, sweep side, whole 32-bit words
    input  wire                        b_wr,
    input  wire  [WORDS_LOG2-1:0]      b_addr,
    input  wire  ram_sweep_pkg::word_t b_din,
    output ram_sweep_pkg::word_t       b_dout
);
    import ram_sweep_pkg::*;

    // Shared storage, one entry per 32-bit word
    word_t mem [0:(1 << WORDS_LOG2) - 1];

    // Port A word index and bit offset of the half
    logic [WORDS_LOG2-1:0] a_word;
    logic [4:0]            a_lsb;

    assign a_word = a_addr[WORDS_LOG2:1];
    // Odd host address is the hi half
    assign a_lsb  = a_addr[0] ? 5'd16 : 5'd0;

    // Both ports on the one clock, single process keeps one driver on mem
    always_ff @(posedge a_clk) begin
        a_dout <= mem[a_word][a_lsb +: HALF_W];
        b_dout <= mem[b_addr];
        // Write first, written data echoed on the port output
        if (a_wr) begin
            mem[a_word][a_lsb +: HALF_W] <= a_din;
            a_dout                       <= a_din;
        end
        // Same-word collision not expected, port B would win here
        if (b_wr) begin
            mem[b_addr] <= b_din;
            b_dout      <= b_din;
        end
    end

endmodule

`default_nettype wire

//--- verilog/half_shift_lane.sv
`timescale 1ns/1ps
`default_nettype none

module half_shift_lane (
    input  wire                            a_clk,
    input  wire                            lane_load,
    input  wire  ram_sweep_pkg::ram_word_u word_in,
    output ram_sweep_pkg::word_t           result,
    output logic                           overflow
);
    import ram_sweep_pkg::*;

    // Sign survives the shift only if the bits shifted out match the new sign
    function automatic logic sign_lost(input half_t h);
        logic [SHIFT_AMOUNT:0] top;
        top = h[HALF_W-1 -: SHIFT_AMOUNT+1];
        return !((&top) || !(|top));
    endfunction

    half_t hi_shift;
    half_t lo_shift;
    logic  hi_lost;
    logic  lo_lost;

    // Each half shifted on its own, low bits kept
    assign hi_shift = half_t'(word_in.halves.hi <<< SHIFT_AMOUNT);
    assign lo_shift = half_t'(word_in.halves.lo <<< SHIFT_AMOUNT);

    assign hi_lost = sign_lost(word_in.halves.hi);
    assign lo_lost = sign_lost(word_in.halves.lo);

    always_ff @(posedge a_clk) begin
        if (lane_load) begin
            result   <= {hi_shift, lo_shift};
            // One flag per word, either half counts
            overflow <= hi_lost | lo_lost;
        end
    end

endmodule

`default_nettype wire

//--- verilog/host_pipe_port.sv
`timescale 1ns/1ps
`default_nettype none

module host_pipe_port #(
    parameter int WORDS_LOG2 = 9
) (
    input  wire                  a_clk,
    input  wire                  reset,
    input  wire                  pipe_in_write,
    input  wire                  pipe_out_read,
    input  wire                  rewind,
    input  wire                  busy,
    output logic [WORDS_LOG2:0]  a_addr,
    output logic                 a_wr
);

    // Pointers count 16-bit halves
    logic [WORDS_LOG2:0] wr_ptr;
    logic [WORDS_LOG2:0] rd_ptr;
    // Address of the last pipe-out read
    logic [WORDS_LOG2:0] last_rd;

    always_ff @(posedge a_clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            last_rd <= '0;
        end else if (rewind) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (pipe_in_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pipe_out_read) begin
                rd_ptr  <= rd_ptr + 1'b1;
                last_rd <= rd_ptr;
            end
        end
    end

    // Write pointer during a pipe-in write, read pointer on a read
    // Idle cycles re-read the last address so pipe_out_data holds
    always_comb begin
        if (pipe_in_write) begin
            a_addr = wr_ptr;
        end else if (pipe_out_read) begin
            a_addr = rd_ptr;
        end else begin
            a_addr = last_rd;
        end
    end

    assign a_wr = pipe_in_write;

    // Host drives one pipe direction at a time
    a_one_pipe_dir : assert property (@(posedge a_clk) disable iff (reset)
        !(pipe_in_write && pipe_out_read));

    // Port A shares the RAM with the sweep, host must stay off it
    a_no_host_busy : assert property (@(posedge a_clk) disable iff (reset)
        busy |-> !(pipe_in_write || pipe_out_read));

endmodule

`default_nettype wire

//--- verilog/ram_sweep_pkg.sv
`default_nettype none

package ram_sweep_pkg;

    // Host word and RAM word widths
    localparam int HALF_W = 16;
    localparam int WORD_W = 32;

    // Left shift distance of the half shift lane
    // Overflow check looks at SHIFT_AMOUNT+1 top bits
    localparam int SHIFT_AMOUNT = 2;

    typedef logic signed [HALF_W-1:0] half_t;
    typedef logic signed [WORD_W-1:0] word_t;

    // Host word 2k is lo, host word 2k+1 is hi
    typedef struct packed {
        half_t hi;
        half_t lo;
    } word_halves_t;

    // One RAM word, seen whole or as two halves
    typedef union packed {
        word_t        whole;
        word_halves_t halves;
    } ram_word_u;

    // Sweep operation, sampled at start
    typedef enum logic {
        MODE_INCREMENT  = 1'b0,
        MODE_HALF_SHIFT = 1'b1
    } mode_e;

endpackage

`default_nettype wire

//--- verilog/ram_sweep_top.sv
`timescale 1ns/1ps
`default_nettype none

module ram_sweep_top #(
    parameter int WORDS_LOG2 = 9
) (
    input  wire                        a_clk,
    input  wire                        reset,
    input  wire                        pipe_in_write,
    input  wire  ram_sweep_pkg::half_t pipe_in_data,
    input  wire                        pipe_out_read,
    input  wire                        rewind,
    input  wire                        start,
    input  wire  ram_sweep_pkg::mode_e mode,
    output ram_sweep_pkg::half_t       pipe_out_data,
    output logic                       busy,
    output logic                       done,
    output logic [15:0]                overflow_count
);
    import ram_sweep_pkg::*;

    // Port A, host side
    logic [WORDS_LOG2:0]   a_addr;
    logic                  a_wr;

    // Port B, sweep side
    logic [WORDS_LOG2-1:0] b_addr;
    logic                  b_wr;
    word_t                 b_din;
    word_t                 b_dout;

    // Lane results back to the sequencer
    logic                  lane_load;
    word_t                 inc_result;
    logic                  inc_overflow;
    word_t                 shift_result;
    logic                  shift_overflow;

    host_pipe_port #(
        .WORDS_LOG2 (WORDS_LOG2)
    ) u_host_pipe_port (
        .a_clk         (a_clk),
        .reset         (reset),
        .pipe_in_write (pipe_in_write),
        .pipe_out_read (pipe_out_read),
        .rewind        (rewind),
        .busy          (busy),
        .a_addr        (a_addr),
        .a_wr          (a_wr)
    );

    // Pipe data straight onto port A
    bram_tdp #(
        .WORDS_LOG2 (WORDS_LOG2)
    ) u_bram_tdp (
        .a_clk  (a_clk),
        .a_wr   (a_wr),
        .a_addr (a_addr),
        .a_din  (pipe_in_data),
        .a_dout (pipe_out_data),
        .b_wr   (b_wr),
        .b_addr (b_addr),
        .b_din  (b_din),
        .b_dout (b_dout)
    );

    // Both lanes see every word read
    word_increment_lane u_word_increment_lane (
        .a_clk     (a_clk),
        .lane_load (lane_load),
        .word_in   (b_dout),
        .result    (inc_result),
        .overflow  (inc_overflow)
    );

    half_shift_lane u_half_shift_lane (
        .a_clk     (a_clk),
        .lane_load (lane_load),
        .word_in   (b_dout),
        .result    (shift_result),
        .overflow  (shift_overflow)
    );

    sweep_sequencer #(
        .WORDS_LOG2 (WORDS_LOG2)
    ) u_sweep_sequencer (
        .a_clk          (a_clk),
        .reset          (reset),
        .start          (start),
        .mode           (mode),
        .b_dout         (b_dout),
        .inc_result     (inc_result),
        .inc_overflow   (inc_overflow),
        .shift_result   (shift_result),
        .shift_overflow (shift_overflow),
        .b_addr         (b_addr),
        .b_wr           (b_wr),
        .b_din          (b_din),
        .lane_load      (lane_load),
        .busy           (busy),
        .done           (done),
        .overflow_count (overflow_count)
    );

endmodule

`default_nettype wire

//--- verilog/sweep_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sweep_sequencer #(
    parameter int WORDS_LOG2 = 9
) (
    input  wire                        a_clk,
    input  wire                        reset,
    input  wire                        start,
    input  wire  ram_sweep_pkg::mode_e mode,
    input  wire  ram_sweep_pkg::word_t b_dout,
    input  wire  ram_sweep_pkg::word_t inc_result,
    input  wire                        inc_overflow,
    input  wire  ram_sweep_pkg::word_t shift_result,
    input  wire                        shift_overflow,
    output logic [WORDS_LOG2-1:0]      b_addr,
    output logic                       b_wr,
    output ram_sweep_pkg::word_t       b_din,
    output logic                       lane_load,
    output logic                       busy,
    output logic                       done,
    output logic [15:0]                overflow_count
);
    import ram_sweep_pkg::*;

    // Three cycles per word
    localparam logic [1:0] PH_ADDR  = 2'd0;
    localparam logic [1:0] PH_DATA  = 2'd1;
    localparam logic [1:0] PH_WRITE = 2'd2;

    localparam logic [WORDS_LOG2-1:0] LAST_INDEX = '1;

    logic [1:0]            phase;
    logic [WORDS_LOG2-1:0] index;
    mode_e                 mode_q;
    logic                  sel_overflow;

    // Lane pick by the mode latched at start
    assign b_din        = (mode_q == MODE_HALF_SHIFT) ? shift_result : inc_result;
    assign sel_overflow = (mode_q == MODE_HALF_SHIFT) ? shift_overflow : inc_overflow;

    // Same word address for read and write-back
    assign b_addr    = index;
    // RAM data valid in the data cycle, lanes grab it
    assign lane_load = busy && (phase == PH_DATA);
    assign b_wr      = busy && (phase == PH_WRITE);

    always_ff @(posedge a_clk) begin
        if (reset) begin
            busy           <= 1'b0;
            done           <= 1'b0;
            phase          <= PH_ADDR;
            index          <= '0;
            mode_q         <= MODE_INCREMENT;
            overflow_count <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                // Start only taken when idle
                if (start) begin
                    busy           <= 1'b1;
                    phase          <= PH_ADDR;
                    index          <= '0;
                    mode_q         <= mode;
                    overflow_count <= '0;
                end
            end else begin
                case (phase)
                    PH_ADDR: begin
                        phase <= PH_DATA;
                    end
                    PH_DATA: begin
                        phase <= PH_WRITE;
                    end
                    default: begin
                        // Write cycle, lane outputs valid now
                        phase <= PH_ADDR;
                        index <= index + 1'b1;
                        if (sel_overflow) begin
                            overflow_count <= overflow_count + 1'b1;
                        end
                        // Last word written, finish next cycle
                        if (index == LAST_INDEX) begin
                            busy <= 1'b0;
                            done <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // A write-back is followed by more sweep or the done pulse
    a_wr_in_sweep : assert property (@(posedge a_clk) disable iff (reset)
        b_wr |-> busy ##1 (busy || done));

    a_done_single : assert property (@(posedge a_clk) disable iff (reset)
        done |=> !done);

    a_busy_done_excl : assert property (@(posedge a_clk) disable iff (reset)
        !(busy && done));

    // RAM echoes the written word next cycle, write-first on port B
    a_wr_echo : assert property (@(posedge a_clk) disable iff (reset)
        b_wr |=> (b_dout == $past(b_din)));

endmodule

`default_nettype wire

//--- verilog/word_increment_lane.sv
`timescale 1ns/1ps
`default_nettype none

module word_increment_lane (
    input  wire                            a_clk,
    input  wire                            lane_load,
    input  wire  ram_sweep_pkg::ram_word_u word_in,
    output ram_sweep_pkg::word_t           result,
    output logic                           overflow
);
    import ram_sweep_pkg::*;

    // Largest positive signed word
    localparam word_t WORD_MAX = {1'b0, {(WORD_W-1){1'b1}}};

    word_t sum;

    // Signed add, wraps to the most negative word
    assign sum = word_t'(word_in.whole + word_t'(1));

    // Held between loads, sampled by the sequencer in the write cycle
    always_ff @(posedge a_clk) begin
        if (lane_load) begin
            result   <= sum;
            // Only the top positive value wraps on +1
            overflow <= (word_in.whole == WORD_MAX);
        end
    end

endmodule

`default_nettype wire
